// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = mboxClkTb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
SIM_ARGS  = +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim.f ====
src/mboxClkPkg.sv
src/diagFuncDecode.sv
src/clkConfigRegs.sv
src/burstCounter.sv
src/runControl.sv
src/diagReadback.sv
src/mboxClkTop.sv
verif/mboxClk_sva.sv
verif/mboxClkTb.sv

// ==== src/burstCounter.sv ====
`timescale 1ns/1ps

module burstCounter import mboxClkPkg::*; #(
  parameter int BURST_W = 8
) (
  input  logic               MBOX_CLK,
  input  logic               CLK,
  input  logic               ldBurstLo,
  input  logic               ldBurstHi,
  input  loadNibble          dataIn,
  input  logic               countEn,
  output logic [BURST_W-1:0] count,
  output logic               burstZero
);

  // Bits above the low nibble, loaded by 043
  localparam int HI_W = BURST_W - NIB_W;

  // Terminal count, shared by run control and read-back
  assign burstZero = (count == '0);

  // Loads take priority over counting
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      count <= '0;
    end else if (ldBurstLo) begin
      count[NIB_W-1:0] <= dataIn.raw;
    end else if (ldBurstHi) begin
      count[BURST_W-1:NIB_W] <= dataIn.raw[HI_W-1:0];
    end else if (countEn && !burstZero) begin
      // One step down per enabled burst tick
      count <= count - 1'b1;
    end
  end

endmodule

// ==== src/clkConfigRegs.sv ====
`timescale 1ns/1ps

module clkConfigRegs import mboxClkPkg::*; (
  input  logic              MBOX_CLK,
  input  logic              CLK,
  input  logic              ldRate,
  input  logic              ldDis,
  input  loadNibble         dataIn,
  output logic [RATE_W-1:0] rateSel,
  output logic              crmDis,
  output logic              edpDis,
  output logic              ctlDis
);

  // Rate select, function 044
  // Source select bits of the board are not kept
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      rateSel <= '0;
    end else if (ldRate) begin
      rateSel <= dataIn.raw[RATE_W-1:0];
    end
  end

  // Section disables, function 045
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      crmDis <= 1'b0;
      edpDis <= 1'b0;
      ctlDis <= 1'b0;
    end else if (ldDis) begin
      crmDis <= dataIn.flags.crmDis;
      edpDis <= dataIn.flags.edpDis;
      ctlDis <= dataIn.flags.ctlDis;
    end
  end

endmodule

// ==== src/diagFuncDecode.sv ====
`timescale 1ns/1ps

module diagFuncDecode import mboxClkPkg::*; (
  input  logic            MBOX_CLK,
  input  logic            CLK,
  input  logic            diagCtl,
  input  logic            diagLd,
  input  logic [DS_W-1:0] ds,
  output logic            fnStart,
  output logic            fnStop,
  output logic            fnStep,
  output logic            fnBurst,
  output logic            ldBurstLo,
  output logic            ldBurstHi,
  output logic            ldRate,
  output logic            ldDis,
  output logic            mrReset
);

  // Reset functions stay local, they only steer the MR flop
  logic fnClrReset;
  logic fnSetReset;

  // One-hot decode, valid only in the strobe cycle
  always_comb begin
    fnStart    = 1'b0;
    fnStop     = 1'b0;
    fnStep     = 1'b0;
    fnBurst    = 1'b0;
    fnClrReset = 1'b0;
    fnSetReset = 1'b0;
    ldBurstLo  = 1'b0;
    ldBurstHi  = 1'b0;
    ldRate     = 1'b0;
    ldDis      = 1'b0;
    if (diagCtl) begin
      case (ds)
        FN_STOP:      fnStop     = 1'b1;
        FN_START:     fnStart    = 1'b1;
        FN_STEP:      fnStep     = 1'b1;
        FN_BURST:     fnBurst    = 1'b1;
        FN_CLR_RESET: fnClrReset = 1'b1;
        FN_SET_RESET: fnSetReset = 1'b1;
        default: ;
      endcase
    end
    // Loads 040, 041, 046 and 047 have no target here
    if (diagLd) begin
      case (ds)
        LD_BURST_LO: ldBurstLo = 1'b1;
        LD_BURST_HI: ldBurstHi = 1'b1;
        LD_RATE:     ldRate    = 1'b1;
        LD_DIS:      ldDis     = 1'b1;
        default: ;
      endcase
    end
  end

  // Master reset flop, set and cleared by diagnostic functions
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      mrReset <= 1'b0;
    end else if (fnSetReset) begin
      mrReset <= 1'b1;
    end else if (fnClrReset) begin
      mrReset <= 1'b0;
    end
  end

endmodule

// ==== src/diagReadback.sv ====
`timescale 1ns/1ps

module diagReadback import mboxClkPkg::*; #(
  parameter int BURST_W = 8
) (
  input  logic               diagRead,
  input  logic [DS_W-1:0]    ds,
  input  logic [BURST_W-1:0] count,
  input  logic               burstZero,
  input  logic               runMode,
  input  logic               burstMode,
  input  logic               mrReset,
  input  logic [RATE_W-1:0]  rateSel,
  input  logic               crmDis,
  input  logic               edpDis,
  input  logic               ctlDis,
  input  logic               eboxClkEn,
  output logic [RD_W-1:0]    dataOut,
  output logic               dataDrive
);

  // Count spread over two read words, low six then top two
  logic [RD_W+1:0] countExt;

  assign countExt  = (RD_W+2)'(count);
  // Bus is driven only in the read cycle
  assign dataDrive = diagRead;

  always_comb begin
    dataOut = '0;
    if (diagRead) begin
      case (ds)
        RD_STATUS:   dataOut = {burstZero, runMode, burstMode, mrReset, rateSel};
        RD_COUNT_LO: dataOut = countExt[RD_W-1:0];
        RD_COUNT_HI: dataOut = {countExt[RD_W+1:RD_W], {(RD_W-2){1'b0}}};
        RD_FLAGS:    dataOut = {crmDis, edpDis, ctlDis, eboxClkEn, {(RD_W-4){1'b0}}};
        // Selects 4 to 7 read as zero
        default:     dataOut = '0;
      endcase
    end
  end

endmodule

// ==== src/mboxClkPkg.sv ====
package mboxClkPkg;

  // Diagnostic bus widths
  localparam int DS_W    = 3;
  localparam int NIB_W   = 4;
  localparam int RD_W    = 6;
  // Burst counter and rate select widths
  localparam int BURST_W = 8;
  localparam int RATE_W  = 2;

  // Control functions, decoded under diagCtl
  localparam logic [DS_W-1:0] FN_STOP      = 3'd0;
  localparam logic [DS_W-1:0] FN_START     = 3'd1;
  localparam logic [DS_W-1:0] FN_STEP      = 3'd2;
  // Codes 3 and 4 are spare
  localparam logic [DS_W-1:0] FN_BURST     = 3'd5;
  localparam logic [DS_W-1:0] FN_CLR_RESET = 3'd6;
  localparam logic [DS_W-1:0] FN_SET_RESET = 3'd7;

  // Load functions under diagLd, 042 through 045 on the board
  localparam logic [DS_W-1:0] LD_BURST_LO  = 3'd2;
  localparam logic [DS_W-1:0] LD_BURST_HI  = 3'd3;
  localparam logic [DS_W-1:0] LD_RATE      = 3'd4;
  localparam logic [DS_W-1:0] LD_DIS       = 3'd5;

  // Read-back select codes under diagRead
  localparam logic [DS_W-1:0] RD_STATUS    = 3'd0;
  localparam logic [DS_W-1:0] RD_COUNT_LO  = 3'd1;
  localparam logic [DS_W-1:0] RD_COUNT_HI  = 3'd2;
  localparam logic [DS_W-1:0] RD_FLAGS     = 3'd3;

  // Section disable flags as they sit in the 045 nibble
  typedef struct packed {
    logic spare;
    logic crmDis;
    logic edpDis;
    logic ctlDis;
  } disFlags;

  // Load data nibble, raw for counter and rate, flags for 045
  typedef union packed {
    logic [NIB_W-1:0] raw;
    disFlags          flags;
  } loadNibble;

endpackage

// ==== src/mboxClkTop.sv ====
`timescale 1ns/1ps

module mboxClkTop import mboxClkPkg::*; (
  input  logic             MBOX_CLK,
  input  logic             CLK,
  input  logic             diagCtl,
  input  logic             diagLd,
  input  logic             diagRead,
  input  logic [DS_W-1:0]  ds,
  input  logic [NIB_W-1:0] dataIn,
  output logic [RD_W-1:0]  dataOut,
  output logic             dataDrive,
  output logic             eboxClkEn,
  output logic             crmClkEn,
  output logic             edpClkEn,
  output logic             ctlClkEn
);

  // Function pulses from the decoder
  logic fnStart;
  logic fnStop;
  logic fnStep;
  logic fnBurst;
  logic ldBurstLo;
  logic ldBurstHi;
  logic ldRate;
  logic ldDis;
  logic mrReset;

  // Configuration state
  logic [RATE_W-1:0] rateSel;
  logic              crmDis;
  logic              edpDis;
  logic              ctlDis;

  // Run control and burst counter state
  logic               runMode;
  logic               burstMode;
  logic               countEn;
  logic [BURST_W-1:0] count;
  logic               burstZero;

  diagFuncDecode diagFuncDecode (
    .MBOX_CLK(MBOX_CLK), .CLK(CLK), .diagCtl(diagCtl), .diagLd(diagLd), .ds(ds),
    .fnStart(fnStart), .fnStop(fnStop), .fnStep(fnStep), .fnBurst(fnBurst),
    .ldBurstLo(ldBurstLo), .ldBurstHi(ldBurstHi), .ldRate(ldRate), .ldDis(ldDis),
    .mrReset(mrReset)
  );

  clkConfigRegs clkConfigRegs (
    .MBOX_CLK(MBOX_CLK), .CLK(CLK), .ldRate(ldRate), .ldDis(ldDis), .dataIn(dataIn),
    .rateSel(rateSel), .crmDis(crmDis), .edpDis(edpDis), .ctlDis(ctlDis)
  );

  burstCounter #(.BURST_W(BURST_W)) burstCounter (
    .MBOX_CLK(MBOX_CLK), .CLK(CLK), .ldBurstLo(ldBurstLo), .ldBurstHi(ldBurstHi),
    .dataIn(dataIn), .countEn(countEn), .count(count), .burstZero(burstZero)
  );

  runControl runControl (
    .MBOX_CLK(MBOX_CLK), .CLK(CLK), .fnStart(fnStart), .fnStop(fnStop),
    .fnStep(fnStep), .fnBurst(fnBurst), .mrReset(mrReset), .rateSel(rateSel),
    .burstZero(burstZero), .crmDis(crmDis), .edpDis(edpDis), .ctlDis(ctlDis),
    .runMode(runMode), .burstMode(burstMode), .countEn(countEn),
    .eboxClkEn(eboxClkEn), .crmClkEn(crmClkEn), .edpClkEn(edpClkEn), .ctlClkEn(ctlClkEn)
  );

  diagReadback #(.BURST_W(BURST_W)) diagReadback (
    .diagRead(diagRead), .ds(ds), .count(count), .burstZero(burstZero),
    .runMode(runMode), .burstMode(burstMode), .mrReset(mrReset), .rateSel(rateSel),
    .crmDis(crmDis), .edpDis(edpDis), .ctlDis(ctlDis), .eboxClkEn(eboxClkEn),
    .dataOut(dataOut), .dataDrive(dataDrive)
  );

endmodule

// ==== src/runControl.sv ====
`timescale 1ns/1ps

module runControl import mboxClkPkg::*; (
  input  logic              MBOX_CLK,
  input  logic              CLK,
  input  logic              fnStart,
  input  logic              fnStop,
  input  logic              fnStep,
  input  logic              fnBurst,
  input  logic              mrReset,
  input  logic [RATE_W-1:0] rateSel,
  input  logic              burstZero,
  input  logic              crmDis,
  input  logic              edpDis,
  input  logic              ctlDis,
  output logic              runMode,
  output logic              burstMode,
  output logic              countEn,
  output logic              eboxClkEn,
  output logic              crmClkEn,
  output logic              edpClkEn,
  output logic              ctlClkEn
);

  // Longest period is 2^(2^RATE_W - 1) cycles
  localparam int DIV_W = (1 << RATE_W) - 1;

  logic [DIV_W-1:0] divCnt;
  logic [DIV_W-1:0] divLast;
  logic             restart;
  logic             tick;
  logic             halt;
  logic             stepReq;
  logic             fire;

  // Divider wraps after 2^rateSel cycles
  assign divLast = DIV_W'((32'd1 << rateSel) - 32'd1);
  assign tick    = (divCnt == divLast);
  // Any go function realigns the divider
  assign restart = fnStart | fnBurst | fnStep;
  assign halt    = fnStop | mrReset;

  // Tick decision, held off for the whole master reset
  assign fire    = tick & ~mrReset & (runMode | (burstMode & ~burstZero) | stepReq);
  assign countEn = fire & burstMode & ~burstZero;

  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      divCnt <= '0;
    end else if (restart || tick) begin
      divCnt <= '0;
    end else begin
      divCnt <= divCnt + 1'b1;
    end
  end

  // Run and burst latches plus single-step request
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      runMode   <= 1'b0;
      burstMode <= 1'b0;
      stepReq   <= 1'b0;
    end else if (halt) begin
      runMode   <= 1'b0;
      burstMode <= 1'b0;
      stepReq   <= 1'b0;
    end else begin
      if (fnStart) begin
        runMode <= 1'b1;
      end
      // Burst drops once the counter has run out
      if (fnBurst) begin
        burstMode <= 1'b1;
      end else if (burstMode && burstZero) begin
        burstMode <= 1'b0;
      end
      // A pending step is used up by its tick
      if (fnStep) begin
        stepReq <= 1'b1;
      end else if (tick) begin
        stepReq <= 1'b0;
      end
    end
  end

  // Registered enables, one cycle after the tick decision
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      eboxClkEn <= 1'b0;
      crmClkEn  <= 1'b0;
      edpClkEn  <= 1'b0;
      ctlClkEn  <= 1'b0;
    end else begin
      eboxClkEn <= fire;
      crmClkEn  <= fire & ~crmDis;
      edpClkEn  <= fire & ~edpDis;
      ctlClkEn  <= fire & ~ctlDis;
    end
  end

endmodule

// ==== verif/mboxClkTb.sv ====
`timescale 1ns/1ps

module mboxClkTb import mboxClkPkg::*; ();

  // Step kinds in the test table
  localparam logic [3:0] K_LOAD  = 4'd0;
  localparam logic [3:0] K_CTL   = 4'd1;
  localparam logic [3:0] K_READ  = 4'd2;
  localparam logic [3:0] K_BURST = 4'd3;
  localparam logic [3:0] K_FIRST = 4'd4;
  localparam logic [3:0] K_GAP   = 4'd5;
  localparam logic [3:0] K_QUIET = 4'd6;

  // One table entry, expVal meaning depends on kind
  typedef struct packed {
    logic [3:0]       kind;
    logic [3:0]       behavior;
    logic [DS_W-1:0]  code;
    logic [NIB_W-1:0] nib;
    logic [31:0]      expVal;
  } testStep;

  logic             MBOX_CLK;
  logic             CLK;
  logic             diagCtl;
  logic             diagLd;
  logic             diagRead;
  logic [DS_W-1:0]  ds;
  logic [NIB_W-1:0] dataIn;
  logic [RD_W-1:0]  dataOut;
  logic             dataDrive;
  logic             eboxClkEn;
  logic             crmClkEn;
  logic             edpClkEn;
  logic             ctlClkEn;

  testStep     steps[$];
  logic [31:0] lfsr;
  int          errCount;
  int          passCount;
  int          errBefore;

  mboxClkTop uut (.*);

  // 20 ns MBOX clock
  always #10 MBOX_CLK = ~MBOX_CLK;

  // Galois LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  task automatic drawBits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsrNext(lfsr);
    end
  endtask

  // Select 0 layout: burstZero, runMode, burstMode, mrReset, rate
  function automatic logic [31:0] statusWord(input logic zero, input logic run,
                                             input logic burst, input logic mr,
                                             input logic [1:0] rate);
    return 32'({zero, run, burst, mr, rate});
  endfunction

  function automatic string kindName(input logic [3:0] kind);
    case (kind)
      K_LOAD:  return "load";
      K_CTL:   return "control";
      K_READ:  return "read";
      K_BURST: return "burst count";
      K_FIRST: return "first pulse";
      K_GAP:   return "pulse spacing";
      K_QUIET: return "no pulses";
      default: return "unknown";
    endcase
  endfunction

  task automatic addStep(input logic [3:0] kind, input logic [3:0] beh,
                         input logic [DS_W-1:0] code, input logic [NIB_W-1:0] nib,
                         input logic [31:0] expVal);
    steps.push_back({kind, beh, code, nib, expVal});
  endtask

  // All driving and sampling happens 2 ns after the rising edge
  task automatic nextCycle();
    @(posedge MBOX_CLK);
    #2;
  endtask

  // Control or load strobe, high for exactly one cycle
  task automatic sendStrobe(input logic isCtl, input logic [DS_W-1:0] code,
                            input logic [NIB_W-1:0] nib);
    ds      = code;
    dataIn  = nib;
    diagCtl = isCtl;
    diagLd  = ~isCtl;
    nextCycle();
    diagCtl = 1'b0;
    diagLd  = 1'b0;
  endtask

  // Combinational read inside the current cycle
  task automatic readWord(input logic [DS_W-1:0] sel, output logic [RD_W-1:0] word);
    ds       = sel;
    diagRead = 1'b1;
    #1;
    word = dataOut;
    assert (dataDrive) else begin
      $display("Error at %0t: dataDrive low during read", $time);
      errCount++;
    end
    diagRead = 1'b0;
    #1;
    assert (!dataDrive) else begin
      $display("Error at %0t: dataDrive high with no read", $time);
      errCount++;
    end
  endtask

  // Edges up to the next enable pulse, -1 when none shows up
  task automatic waitPulse(input int limit, output int edges);
    edges = 0;
    do begin
      nextCycle();
      edges++;
    end while (!eboxClkEn && edges < limit);
    if (!eboxClkEn) begin
      $display("Timeout waiting for enable pulse at %0t", $time);
      errCount++;
      edges = -1;
    end
  endtask

  task automatic runStep(input testStep s);
    logic [RD_W-1:0] word;
    int edges;
    int pulses;
    int limit;
    case (s.kind)
      K_LOAD: sendStrobe(1'b0, s.code, s.nib);
      K_CTL:  sendStrobe(1'b1, s.code, s.nib);
      K_READ: begin
        readWord(s.code, word);
        assert (word == s.expVal[RD_W-1:0]) else begin
          $display("Error at %0t: select %0d read %h, expected %h", $time, s.code,
                   word, s.expVal[RD_W-1:0]);
          errCount++;
        end
      end
      K_BURST: begin
        // Count pulses until burstMode drops in the status word
        limit  = (int'(s.expVal) + 2) * (1 << int'(s.nib[1:0])) + 8;
        sendStrobe(1'b1, FN_BURST, 4'd0);
        pulses = 0;
        edges  = 0;
        do begin
          if (eboxClkEn) begin
            pulses++;
          end
          readWord(RD_STATUS, word);
          if (word[3]) begin
            nextCycle();
          end
          edges++;
        end while (word[3] && edges < limit);
        if (word[3]) begin
          $display("Timeout waiting for burst mode to end at %0t", $time);
          errCount++;
        end
        assert (pulses == int'(s.expVal)) else begin
          $display("Error at %0t: burst gave %0d pulses, expected %0d", $time, pulses,
                   s.expVal);
          errCount++;
        end
      end
      K_FIRST: begin
        // Strobe edge counts as the first edge
        sendStrobe(1'b1, s.code, 4'd0);
        edges = 1;
        if (!eboxClkEn) begin
          waitPulse(40, limit);
          edges = (limit < 0) ? -1 : limit + 1;
        end
        assert (edges == int'(s.expVal)) else begin
          $display("Error at %0t: first pulse after %0d edges, expected %0d", $time,
                   edges, s.expVal);
          errCount++;
        end
      end
      K_GAP: begin
        waitPulse(40, edges);
        assert (edges == int'(s.expVal)) else begin
          $display("Error at %0t: pulse spacing %0d, expected %0d", $time, edges,
                   s.expVal);
          errCount++;
        end
        // Masked sections stay low, the others follow eboxClkEn
        assert ({crmClkEn, edpClkEn, ctlClkEn} == ~s.nib[2:0]) else begin
          $display("Error at %0t: section enables %b, disables %b", $time,
                   {crmClkEn, edpClkEn, ctlClkEn}, s.nib[2:0]);
          errCount++;
        end
      end
      K_QUIET: begin
        pulses = 0;
        repeat (int'(s.expVal)) begin
          nextCycle();
          if (eboxClkEn || crmClkEn || edpClkEn || ctlClkEn) begin
            pulses++;
          end
        end
        assert (pulses == 0) else begin
          $display("Error at %0t: %0d enable pulses where none were due", $time, pulses);
          errCount++;
        end
      end
      default: ;
    endcase
  endtask

  initial begin
    logic [31:0] rnd;
    logic [3:0]  rateNib;
    logic [3:0]  disNib;
    logic [7:0]  burstN;
    logic [1:0]  stepRate;
    logic [1:0]  runRate;
    logic [2:0]  runDis;
    MBOX_CLK  = 1'b0;
    CLK       = 1'b1;
    diagCtl   = 1'b0;
    diagLd    = 1'b0;
    diagRead  = 1'b0;
    ds        = '0;
    dataIn    = '0;
    errCount  = 0;
    passCount = 0;
    lfsr      = 32'h8af981ec;

    drawBits(4, rnd);
    rateNib = rnd[3:0];
    drawBits(4, rnd);
    disNib = rnd[3:0];
    drawBits(8, rnd);
    burstN = rnd[7:0];
    drawBits(2, rnd);
    stepRate = rnd[1:0];
    drawBits(2, rnd);
    runRate = rnd[1:0];
    drawBits(3, rnd);
    runDis = rnd[2:0];
    // Want some sections masked and some running
    if (runDis == 3'b000 || runDis == 3'b111) begin
      runDis = 3'b101;
    end

    // After reset, counter is zero so burstZero reads 1
    addStep(K_READ, 4'd1, RD_STATUS, 4'd0, statusWord(1'b1, 1'b0, 1'b0, 1'b0, 2'd0));
    addStep(K_READ, 4'd1, RD_FLAGS, 4'd0, 32'd0);
    // Rate and disables read back
    addStep(K_LOAD, 4'd2, LD_RATE, rateNib, 32'd0);
    addStep(K_LOAD, 4'd2, LD_DIS, disNib, 32'd0);
    addStep(K_READ, 4'd2, RD_STATUS, 4'd0,
            statusWord(1'b1, 1'b0, 1'b0, 1'b0, rateNib[1:0]));
    addStep(K_READ, 4'd2, RD_FLAGS, 4'd0, 32'({disNib[2:0], 3'b000}));
    // Burst of N pulses
    addStep(K_LOAD, 4'd3, LD_BURST_LO, burstN[3:0], 32'd0);
    addStep(K_LOAD, 4'd3, LD_BURST_HI, burstN[7:4], 32'd0);
    addStep(K_READ, 4'd3, RD_COUNT_LO, 4'd0, 32'(burstN[5:0]));
    addStep(K_READ, 4'd3, RD_COUNT_HI, 4'd0, 32'({burstN[7:6], 4'b0000}));
    addStep(K_BURST, 4'd3, FN_BURST, rateNib, 32'(burstN));
    addStep(K_READ, 4'd3, RD_STATUS, 4'd0,
            statusWord(1'b1, 1'b0, 1'b0, 1'b0, rateNib[1:0]));
    // Single step
    addStep(K_LOAD, 4'd4, LD_RATE, {2'b00, stepRate}, 32'd0);
    addStep(K_FIRST, 4'd4, FN_STEP, 4'd0, 32'((1 << int'(stepRate)) + 1));
    addStep(K_QUIET, 4'd4, 3'd0, 4'd0, 32'((2 << int'(stepRate)) + 4));
    // Run, spacing, section masks, stop
    addStep(K_LOAD, 4'd5, LD_RATE, {2'b00, runRate}, 32'd0);
    addStep(K_LOAD, 4'd5, LD_DIS, {1'b0, runDis}, 32'd0);
    addStep(K_FIRST, 4'd5, FN_START, 4'd0, 32'((1 << int'(runRate)) + 1));
    addStep(K_GAP, 4'd5, 3'd0, {1'b0, runDis}, 32'(1 << int'(runRate)));
    addStep(K_GAP, 4'd5, 3'd0, {1'b0, runDis}, 32'(1 << int'(runRate)));
    addStep(K_CTL, 4'd5, FN_STOP, 4'd0, 32'd0);
    addStep(K_QUIET, 4'd5, 3'd0, 4'd0, 32'((2 << int'(runRate)) + 4));
    // Master reset blocks start
    addStep(K_CTL, 4'd6, FN_SET_RESET, 4'd0, 32'd0);
    addStep(K_READ, 4'd6, RD_STATUS, 4'd0, statusWord(1'b1, 1'b0, 1'b0, 1'b1, runRate));
    addStep(K_CTL, 4'd6, FN_START, 4'd0, 32'd0);
    addStep(K_QUIET, 4'd6, 3'd0, 4'd0, 32'((2 << int'(runRate)) + 4));
    addStep(K_CTL, 4'd6, FN_CLR_RESET, 4'd0, 32'd0);
    addStep(K_READ, 4'd6, RD_STATUS, 4'd0, statusWord(1'b1, 1'b0, 1'b0, 1'b0, runRate));

    // Reset for 4 cycles, released off the edge
    repeat (4) @(posedge MBOX_CLK);
    #2;
    CLK = 1'b0;

    for (int i = 0; i < steps.size(); i++) begin
      errBefore = errCount;
      runStep(steps[i]);
      if (errCount == errBefore) begin
        passCount++;
        $display("Test %0d, behavior %0d, %s: passed", i, steps[i].behavior,
                 kindName(steps[i].kind));
      end else begin
        $display("Test %0d, behavior %0d, %s: failed", i, steps[i].behavior,
                 kindName(steps[i].kind));
      end
    end

    // Concurrent assertion failures count too
    errCount = errCount + uut.runControl.svaCheck.failCount;
    $display("Tests passed %0d, failed %0d, errors %0d", passCount,
             steps.size() - passCount, errCount);
    if (errCount == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== verif/mboxClk_sva.sv ====
`timescale 1ns/1ps

module mboxClkSva import mboxClkPkg::*; (
  input logic              MBOX_CLK,
  input logic              CLK,
  input logic [RATE_W-1:0] rateSel,
  input logic              mrReset,
  input logic              eboxClkEn,
  input logic              crmClkEn,
  input logic              edpClkEn,
  input logic              ctlClkEn
);

  int failCount = 0;

  // Section enables only pulse along with the EBOX enable
  sectionInEbox: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    (crmClkEn || edpClkEn || ctlClkEn) |-> eboxClkEn)
  else begin
    $error("section clock enable high without eboxClkEn");
    failCount++;
  end

  // Divided rates give isolated one-cycle pulses
  singlePulse: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    (eboxClkEn && rateSel != '0) |=> !eboxClkEn)
  else begin
    $error("eboxClkEn longer than one cycle at a divided rate");
    failCount++;
  end

  // Master reset holds every enable off
  quietInReset: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    mrReset |=> !(eboxClkEn || crmClkEn || edpClkEn || ctlClkEn))
  else begin
    $error("clock enable pulsed during master reset");
    failCount++;
  end

endmodule

bind runControl mboxClkSva svaCheck (
  .MBOX_CLK(MBOX_CLK), .CLK(CLK), .rateSel(rateSel), .mrReset(mrReset),
  .eboxClkEn(eboxClkEn), .crmClkEn(crmClkEn), .edpClkEn(edpClkEn), .ctlClkEn(ctlClkEn)
);
